// File: lsd_cfg.svh
`ifndef LSD_CFG_SVH
`define LSD_CFG_SVH

// fetch group width in instructions
`define LSD_LANES 4

// loop address table entries
`define LSD_TABLE_DEPTH 4

// instructions a single dispatch may hand out
// also the dividend of the max unroll rule
`define LSD_UNROLL_BUDGET 64

// bytes per instruction, fallthrough = branch pc + this
`define LSD_INST_BYTES 4

`endif

// File: lsd_pkg.sv
`default_nettype none
`include "lsd_cfg.svh"

package lsd_pkg;

	typedef logic [15:0] pc_t;

	typedef logic [6:0] inst_cnt_t;  // 0 to 64

	typedef logic [$clog2(`LSD_LANES + 1)-1:0] lane_cnt_t;

	// reported loop buffer state
	typedef enum logic [1:0] {
		IDLE     = 2'b00,
		TRAIN    = 2'b01,
		DISPATCH = 2'b10
	} lsd_state_e;

	// 46 bits, valid bit lives in the table
	typedef struct packed {
		pc_t       start_pc;
		pc_t       fallthrough_pc;
		inst_cnt_t num_insts;
		inst_cnt_t max_unroll;
	} lat_entry_t;

	// lane 0 sits in the top bits
	function automatic pc_t lane_pc(input logic [`LSD_LANES*$bits(pc_t)-1:0] grp,
		input int lane);
		return grp[(`LSD_LANES - 1 - lane)*$bits(pc_t) +: $bits(pc_t)];
	endfunction

	// lanes up to and including the loop end, 0 when the group holds no end
	function automatic lane_cnt_t end_count(input logic [`LSD_LANES*$bits(pc_t)-1:0] grp,
		input pc_t fall);
		lane_cnt_t cnt;
		cnt = '0;
		for (int i = `LSD_LANES - 1; i >= 0; i--) begin
			if (lane_pc(grp, i) == fall - pc_t'(`LSD_INST_BYTES))
				cnt = lane_cnt_t'(i + 1);  // lowest lane wins
		end
		return cnt;
	endfunction

endpackage

`default_nettype wire

// File: lat_if.sv
`timescale 1ns/1ps
`default_nettype none

interface lat_if;
	import lsd_pkg::*;

	// write side, lands at the edge after wr_en
	logic       wr_en;
	lat_entry_t wr_entry;

	// combinational start address lookup
	pc_t        lookup_pc;
	logic       hit;
	lat_entry_t hit_entry;

	modport detector (
		output wr_en,
		output wr_entry,
		input  hit
	);

	modport tbl (
		input  wr_en,
		input  wr_entry,
		input  lookup_pc,
		output hit,
		output hit_entry
	);

	modport dispatcher (
		output lookup_pc,
		input  hit,
		input  hit_entry
	);

endinterface

`default_nettype wire

// File: loop_detect.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsd_cfg.svh"

module loop_detect (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     fetch_valid,
	input  logic [`LSD_LANES*16-1:0] pc_group,
	input  logic [`LSD_LANES-1:0]    back_branch,
	input  logic                     dispatching,
	lat_if.detector                  lat,
	output lsd_pkg::lsd_state_e      train_state
);
	import lsd_pkg::*;

	lsd_state_e state;
	pc_t        fall_pc;
	pc_t        start_pc;
	logic       first_grp;  // next group gives start_pc
	inst_cnt_t  inst_cnt;

	logic       grp_ok;
	logic       seen_branch;
	pc_t        branch_fall;
	lane_cnt_t  end_cnt;
	inst_cnt_t  cnt_next;
	pc_t        start_next;
	inst_cnt_t  unroll_next;

	// groups during dispatch belong to the controller
	assign grp_ok      = fetch_valid && !dispatching;
	assign seen_branch = |back_branch;
	assign train_state = state;

	// fallthrough of the lowest flagged lane
	always_comb begin
		branch_fall = '0;
		for (int i = `LSD_LANES - 1; i >= 0; i--) begin
			if (back_branch[`LSD_LANES-1-i])
				branch_fall = lane_pc(pc_group, i) + pc_t'(`LSD_INST_BYTES);
		end
	end

	assign end_cnt    = end_count(pc_group, fall_pc);
	assign cnt_next   = inst_cnt + ((end_cnt != '0) ? inst_cnt_t'(end_cnt)
		: inst_cnt_t'(`LSD_LANES));
	assign start_next = first_grp ? lane_pc(pc_group, 0) : start_pc;

	// floor(64 / length), lengths past the budget give 0
	always_comb begin
		case (cnt_next) inside
			7'd1:          unroll_next = 7'd64;
			7'd2:          unroll_next = 7'd32;
			7'd3:          unroll_next = 7'd21;
			7'd4:          unroll_next = 7'd16;
			7'd5:          unroll_next = 7'd12;
			7'd6:          unroll_next = 7'd10;
			7'd7:          unroll_next = 7'd9;
			7'd8:          unroll_next = 7'd8;
			7'd9:          unroll_next = 7'd7;
			7'd10:         unroll_next = 7'd6;
			[7'd11:7'd12]: unroll_next = 7'd5;
			[7'd13:7'd16]: unroll_next = 7'd4;
			[7'd17:7'd21]: unroll_next = 7'd3;
			[7'd22:7'd32]: unroll_next = 7'd2;
			[7'd33:7'd64]: unroll_next = 7'd1;
			default:       unroll_next = 7'd0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= IDLE;
			first_grp <= 1'b0;
			inst_cnt  <= '0;
			lat.wr_en <= 1'b0;
		end else begin
			lat.wr_en <= 1'b0;
			if (grp_ok) begin
				case (state)
					IDLE: begin
						if (seen_branch && !lat.hit) begin
							state     <= TRAIN;
							first_grp <= 1'b1;
							inst_cnt  <= '0;
						end
					end
					TRAIN: begin
						first_grp <= 1'b0;
						if (lat.hit) begin
							state <= IDLE;  // dispatch takes over
						end else if (cnt_next > inst_cnt_t'(`LSD_UNROLL_BUDGET)) begin
							state <= IDLE;  // too long to buffer
						end else if (end_cnt != '0) begin
							state     <= IDLE;
							lat.wr_en <= 1'b1;
						end else begin
							inst_cnt <= cnt_next;
						end
					end
					default: state <= IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (grp_ok && state == IDLE && seen_branch)
			fall_pc <= branch_fall;
		if (grp_ok && state == TRAIN) begin
			start_pc     <= start_next;
			lat.wr_entry <= '{start_pc:       start_next,
			                  fallthrough_pc: fall_pc,
			                  num_insts:      cnt_next,
			                  max_unroll:     unroll_next};
		end
	end

	wr_only_after_train: assert property (@(posedge clk) disable iff (rst)
		lat.wr_en |-> $past(state) == TRAIN);

endmodule

`default_nettype wire

// File: loop_addr_table.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsd_cfg.svh"

module loop_addr_table (
	input logic clk,
	input logic rst,
	lat_if.tbl  lat
);
	import lsd_pkg::*;

	localparam int PTR_W = $clog2(`LSD_TABLE_DEPTH);

	lat_entry_t                  entry [`LSD_TABLE_DEPTH];
	logic [`LSD_TABLE_DEPTH-1:0] valid;
	logic [PTR_W-1:0]            wr_ptr;  // round robin victim

	logic [`LSD_TABLE_DEPTH-1:0] look_match;
	logic [`LSD_TABLE_DEPTH-1:0] wr_match;
	logic                        wr_dup;
	logic [PTR_W-1:0]            wr_idx;

	always_comb begin
		for (int i = 0; i < `LSD_TABLE_DEPTH; i++) begin
			look_match[i] = valid[i] && (entry[i].start_pc == lat.lookup_pc);
			wr_match[i]   = valid[i] && (entry[i].start_pc == lat.wr_entry.start_pc);
		end
	end

	assign lat.hit = |look_match;

	// one-hot select
	always_comb begin
		lat.hit_entry = '0;
		for (int i = 0; i < `LSD_TABLE_DEPTH; i++) begin
			if (look_match[i])
				lat.hit_entry = lat.hit_entry | entry[i];
		end
	end

	// a retrained loop overwrites its own slot
	always_comb begin
		wr_dup = |wr_match;
		wr_idx = wr_ptr;
		for (int i = 0; i < `LSD_TABLE_DEPTH; i++) begin
			if (wr_match[i])
				wr_idx = PTR_W'(i);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid  <= '0;
			wr_ptr <= '0;
		end else if (lat.wr_en) begin
			valid[wr_idx] <= 1'b1;
			if (!wr_dup) begin
				if (wr_ptr == PTR_W'(`LSD_TABLE_DEPTH - 1))
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (lat.wr_en)
			entry[wr_idx] <= lat.wr_entry;
	end

	single_match: assert property (@(posedge clk) disable iff (rst)
		$onehot0(look_match));

endmodule

`default_nettype wire

// File: unroll_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsd_cfg.svh"

module unroll_ctrl (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     fetch_valid,
	input  logic [`LSD_LANES*16-1:0] pc_group,
	input  logic                     mis_pred,
	lat_if.dispatcher                lat,
	output logic                     dispatching,
	output logic                     loop_start,
	output logic [`LSD_LANES-1:0]    lane_valid,
	output logic                     lane_valid_strobe,
	output logic                     stall_fetch,
	output logic                     finish_unroll
);
	import lsd_pkg::*;

	localparam int CNT_W = $clog2(`LSD_UNROLL_BUDGET) + 1;

	lsd_state_e          state;
	pc_t                 loop_fall;  // fallthrough of the loop in flight
	inst_cnt_t           remaining;  // iterations left
	logic [CNT_W-1:0]    disp_cnt;   // lanes handed out, saturates at budget

	logic                grp_hit;
	logic                take;
	pc_t                 fall_cur;
	inst_cnt_t           rem_cur;
	lane_cnt_t           end_cnt;
	lane_cnt_t           n_valid;
	logic                last_iter;
	logic [`LSD_LANES-1:0] mask;
	logic [CNT_W-1:0]    cnt_sum;
	logic [CNT_W-1:0]    cnt_next;

	assign lat.lookup_pc = lane_pc(pc_group, 0);
	assign grp_hit       = fetch_valid && lat.hit;
	assign loop_start    = grp_hit;
	assign dispatching   = (state == DISPATCH);

	// the hitting group is decoded against the entry it hit
	assign fall_cur = dispatching ? loop_fall : lat.hit_entry.fallthrough_pc;
	assign rem_cur  = dispatching ? remaining : lat.hit_entry.max_unroll;
	assign take     = dispatching ? (fetch_valid && !mis_pred) : grp_hit;

	assign end_cnt   = end_count(pc_group, fall_cur);
	assign n_valid   = (end_cnt != '0) ? end_cnt : lane_cnt_t'(`LSD_LANES);
	assign last_iter = (end_cnt != '0) && (rem_cur == inst_cnt_t'(1));
	assign cnt_sum   = disp_cnt + CNT_W'(n_valid);
	assign cnt_next  = (cnt_sum > CNT_W'(`LSD_UNROLL_BUDGET)) ? CNT_W'(`LSD_UNROLL_BUDGET)
		: cnt_sum;

	// lane 0 on bit msb, lanes past the end masked
	always_comb begin
		for (int i = 0; i < `LSD_LANES; i++)
			mask[`LSD_LANES-1-i] = (i < int'(n_valid));
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state             <= IDLE;
			remaining         <= '0;
			disp_cnt          <= '0;
			lane_valid        <= '0;
			lane_valid_strobe <= 1'b0;
			stall_fetch       <= 1'b0;
			finish_unroll     <= 1'b0;
		end else begin
			lane_valid_strobe <= take;
			lane_valid        <= take ? mask : '0;
			finish_unroll     <= take && last_iter;
			if ((dispatching && mis_pred) || (take && last_iter)) begin
				state       <= IDLE;  // abort or done, table untouched
				remaining   <= '0;
				disp_cnt    <= '0;
				stall_fetch <= 1'b0;
			end else if (take) begin
				state       <= DISPATCH;
				remaining   <= (end_cnt != '0) ? rem_cur - 1'b1 : rem_cur;
				disp_cnt    <= cnt_next;
				stall_fetch <= (cnt_next >= CNT_W'(`LSD_UNROLL_BUDGET));
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!dispatching && grp_hit)
			loop_fall <= lat.hit_entry.fallthrough_pc;
	end

	stall_in_dispatch: assert property (@(posedge clk) disable iff (rst)
		stall_fetch |-> dispatching);

	finish_one_cycle: assert property (@(posedge clk) disable iff (rst)
		finish_unroll |=> !finish_unroll);

endmodule

`default_nettype wire

// File: loop_stream_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsd_cfg.svh"

module loop_stream_top (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     fetch_valid,
	input  logic [`LSD_LANES*16-1:0] pc_group,     // lane 0 on top
	input  logic [`LSD_LANES-1:0]    back_branch,  // bit msb is lane 0
	input  logic                     mis_pred,
	output lsd_pkg::lsd_state_e      lbd_state,
	output logic                     loop_start,
	output logic [`LSD_LANES-1:0]    lane_valid,
	output logic                     lane_valid_strobe,
	output logic                     stall_fetch,
	output logic                     finish_unroll
);
	import lsd_pkg::*;

	lsd_state_e train_state;
	logic       dispatching;

	lat_if lat_bus ();

	loop_detect u_detect (
		.clk         (clk),
		.rst         (rst),
		.fetch_valid (fetch_valid),
		.pc_group    (pc_group),
		.back_branch (back_branch),
		.dispatching (dispatching),
		.lat         (lat_bus),
		.train_state (train_state)
	);

	loop_addr_table u_table (
		.clk (clk),
		.rst (rst),
		.lat (lat_bus)
	);

	unroll_ctrl u_ctrl (
		.clk               (clk),
		.rst               (rst),
		.fetch_valid       (fetch_valid),
		.pc_group          (pc_group),
		.mis_pred          (mis_pred),
		.lat               (lat_bus),
		.dispatching       (dispatching),
		.loop_start        (loop_start),
		.lane_valid        (lane_valid),
		.lane_valid_strobe (lane_valid_strobe),
		.stall_fetch       (stall_fetch),
		.finish_unroll     (finish_unroll)
	);

	// dispatch outranks training
	assign lbd_state = dispatching ? DISPATCH : train_state;

endmodule

`default_nettype wire

// File: tb_loop_stream.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsd_cfg.svh"

module tb_loop_stream;
	import lsd_pkg::*;

	logic                     clk;
	logic                     rst;
	logic                     fetch_valid;
	logic [`LSD_LANES*16-1:0] pc_group;
	logic [`LSD_LANES-1:0]    back_branch;
	logic                     mis_pred;
	lsd_state_e               lbd_state;
	logic                     loop_start;
	logic [`LSD_LANES-1:0]    lane_valid;
	logic                     lane_valid_strobe;
	logic                     stall_fetch;
	logic                     finish_unroll;

	int          err_cnt;
	int          test_cnt;
	int          errs_before;
	logic        seen_start;   // loop_start just after the drive
	logic        saw_finish;
	logic [31:0] rnd_state;

	// reference model of the loop in flight
	logic m_active;
	pc_t  m_fall;
	int   m_unroll;
	int   m_rem;
	int   m_cum;
	int   m_ends;

	loop_stream_top UUT (
		.clk               (clk),
		.rst               (rst),
		.fetch_valid       (fetch_valid),
		.pc_group          (pc_group),
		.back_branch       (back_branch),
		.mis_pred          (mis_pred),
		.lbd_state         (lbd_state),
		.loop_start        (loop_start),
		.lane_valid        (lane_valid),
		.lane_valid_strobe (lane_valid_strobe),
		.stall_fetch       (stall_fetch),
		.finish_unroll     (finish_unroll)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] lcg_next();
		rnd_state = rnd_state * 32'd1103515245 + 32'd12345;
		return rnd_state;
	endfunction

	function automatic int exp_unroll(input int len);
		return (len > `LSD_UNROLL_BUDGET) ? 0 : `LSD_UNROLL_BUDGET / len;
	endfunction

	// lane holding the branch or -1
	function automatic int end_lane(input pc_t base, input pc_t fall);
		int j;
		j = -1;
		for (int i = `LSD_LANES - 1; i >= 0; i--) begin
			if (base + pc_t'(`LSD_INST_BYTES * i) == fall - pc_t'(`LSD_INST_BYTES))
				j = i;
		end
		return j;
	endfunction

	function automatic logic [3:0] lane_mask(input int j);
		logic [3:0] m;
		m = '0;
		for (int i = 0; i < `LSD_LANES; i++) begin
			if (j < 0 || i <= j)
				m[3-i] = 1'b1;  // lane 0 on msb
		end
		return m;
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		assert (got == exp) else begin
			$display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	task automatic end_test(input string name);
		test_cnt++;
		if (err_cnt == errs_before)
			$display("test %0d %s: ok", test_cnt, name);
		else
			$display("test %0d %s: %0d errors", test_cnt, name, err_cnt - errs_before);
		errs_before = err_cnt;
	endtask

	task automatic apply_reset();
		rst         = 1'b1;
		fetch_valid = 1'b0;
		back_branch = '0;
		mis_pred    = 1'b0;
		repeat (8) @(negedge clk);
		rst      = 1'b0;
		m_active = 1'b0;
	endtask

	task automatic idle(input int n);
		fetch_valid = 1'b0;
		back_branch = '0;
		repeat (n) @(negedge clk);
	endtask

	// four consecutive addresses from base
	task automatic send_group(input pc_t base, input logic [3:0] bb);
		fetch_valid = 1'b1;
		pc_group    = {base, pc_t'(base + 16'd4), pc_t'(base + 16'd8), pc_t'(base + 16'd12)};
		back_branch = bb;
		#1 seen_start = loop_start;
		@(negedge clk);
	endtask

	task automatic train_loop(input pc_t start, input int len);
		pc_t br_base;
		int  lane;
		br_base = start + pc_t'(16 * ((len - 1) / 4));
		lane    = (len - 1) % 4;
		send_group(br_base, 4'b1000 >> lane);
		check("lbd_state after branch", lbd_state, TRAIN);
		for (int g = 0; g <= (len - 1) / 4; g++)
			send_group(start + pc_t'(16 * g), '0);
		check("lbd_state after loop end", lbd_state, IDLE);
		idle(1);  // write lands
	endtask

	task automatic disp_group(input pc_t base);
		int         j;
		logic       fin;
		logic [3:0] mask;
		j    = end_lane(base, m_fall);
		mask = lane_mask(j);
		send_group(base, '0);
		if (!m_active) begin
			check("loop_start on entry", seen_start, 1);
			m_active = 1'b1;
			m_rem    = m_unroll;
			m_cum    = 0;
			m_ends   = 0;
		end
		if (j >= 0) begin
			m_rem--;
			m_ends++;
		end
		m_cum = m_cum + ((j < 0) ? 4 : j + 1);
		fin = (j >= 0) && (m_rem == 0);
		if (fin)
			m_active = 1'b0;
		saw_finish = finish_unroll;
		check("lane_valid_strobe", lane_valid_strobe, 1);
		check("lane_valid", lane_valid, mask);
		check("finish_unroll", finish_unroll, fin);
		check("stall_fetch", stall_fetch, !fin && m_cum >= `LSD_UNROLL_BUDGET);
		check("lbd_state in dispatch", lbd_state, fin ? IDLE : DISPATCH);
	endtask

	// whole iterations until the DUT reports finish
	task automatic dispatch_loop(input pc_t start, input int len, output int iters);
		int guard;
		m_fall     = start + pc_t'(`LSD_INST_BYTES * len);
		m_unroll   = exp_unroll(len);
		saw_finish = 1'b0;
		guard      = 0;
		while (!saw_finish && guard < 80) begin
			for (int g = 0; g <= (len - 1) / 4; g++) begin
				if (!saw_finish)
					disp_group(start + pc_t'(16 * g));
			end
			guard++;
		end
		if (!saw_finish) begin
			$display("timeout: no finish_unroll after %0d iterations of loop %h", guard, start);
			err_cnt++;
		end
		iters    = m_ends;
		m_active = 1'b0;
		idle(1);
	endtask

	initial begin
		int   iters;
		int   guard;
		logic saw_stall;
		int   len [5];
		clk         = 1'b0;
		rst         = 1'b1;
		fetch_valid = 1'b0;
		pc_group    = '0;
		back_branch = '0;
		mis_pred    = 1'b0;
		err_cnt     = 0;
		test_cnt    = 0;
		errs_before = 0;
		rnd_state   = 32'd48963;
		saw_finish  = 1'b0;

		apply_reset();
		check("loop_start", loop_start, 0);
		check("lane_valid_strobe", lane_valid_strobe, 0);
		check("lane_valid", lane_valid, 0);
		check("stall_fetch", stall_fetch, 0);
		check("finish_unroll", finish_unroll, 0);
		check("lbd_state", lbd_state, IDLE);
		end_test("reset");

		train_loop(16'h0100, 6);
		dispatch_loop(16'h0100, 6, iters);
		check("loop-end groups to finish", iters, exp_unroll(6));
		end_test("train and dispatch 6");

		train_loop(16'h0200, 64);
		dispatch_loop(16'h0200, 64, iters);
		check("loop-end groups to finish", iters, exp_unroll(64));
		train_loop(16'h0400, 65);
		send_group(16'h0400, '0);
		check("loop_start for 65 insts", seen_start, 0);
		idle(1);
		check("lbd_state after miss", lbd_state, IDLE);
		end_test("length limits");

		train_loop(16'h0600, 2);
		m_fall     = 16'h0608;
		m_unroll   = exp_unroll(2);
		saw_finish = 1'b0;
		saw_stall  = 1'b0;
		disp_group(16'h0600);
		guard = 0;
		while (!saw_finish && guard < 64) begin
			disp_group(16'h05f8);  // four lanes per group with the end in lane 3
			saw_stall = saw_stall | stall_fetch;
			guard++;
		end
		if (!saw_finish) begin
			$display("timeout: no finish_unroll during the stall test");
			err_cnt++;
		end
		check("stall_fetch seen", saw_stall, 1);
		check("loop-end groups to finish", m_ends, exp_unroll(2));
		m_active = 1'b0;
		idle(1);
		end_test("stall");

		m_fall   = 16'h0608;
		m_unroll = exp_unroll(2);
		disp_group(16'h0600);
		for (int g = 0; g < 16; g++)
			disp_group(16'h05f8);  // runs past the budget so stall is up
		fetch_valid = 1'b0;
		mis_pred    = 1'b1;
		@(negedge clk);
		mis_pred = 1'b0;
		m_active = 1'b0;
		check("lbd_state after mispredict", lbd_state, IDLE);
		check("finish_unroll after mispredict", finish_unroll, 0);
		check("lane_valid_strobe after mispredict", lane_valid_strobe, 0);
		check("stall_fetch after mispredict", stall_fetch, 0);
		dispatch_loop(16'h0600, 2, iters);
		check("loop-end groups after restart", iters, exp_unroll(2));
		end_test("mispredict");

		apply_reset();
		for (int k = 0; k < 5; k++) begin
			len[k] = int'((lcg_next() >> 16) % 64) + 1;
			train_loop(pc_t'(16'h1000 + 16'h0200 * k), len[k]);
		end
		send_group(16'h1000, '0);
		check("loop_start for evicted loop", seen_start, 0);
		idle(1);
		check("lbd_state after evicted start", lbd_state, IDLE);
		for (int k = 1; k < 5; k++) begin
			dispatch_loop(pc_t'(16'h1000 + 16'h0200 * k), len[k], iters);
			check("loop-end groups to finish", iters, exp_unroll(len[k]));
		end
		end_test("replacement");

		$display("tests run %0d, errors %0d", test_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+.
lsd_pkg.sv
lat_if.sv
loop_detect.sv
loop_addr_table.sv
unroll_ctrl.sv
loop_stream_top.sv
tb_loop_stream.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the loop stream testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_loop_stream \
	-f compile.f \
	-o sim_loop_stream

./obj_dir/sim_loop_stream | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
	echo "run passed"
	exit 0
fi

echo "run failed, see sim.log"
exit 1
